/* all.f */
+incdir+logic
logic/issue_pkg.sv
logic/dec_if.sv
logic/apb_fetch.sv
logic/decode.sv
logic/dispatch.sv
logic/issue_top.sv
dv/tb_clock.sv
dv/issue_tb.sv

/* dv/issue_tb.sv */
`include "issue_defs.svh"

module issue_tb;

    localparam int LIMIT = 6000;   // cycles, well above the longest test sequence

    typedef struct packed {
        logic        valid;
        logic [5:0]  op;
        logic [1:0]  cls;
        logic [1:0]  slot;
        logic [2:0]  dest;
        logic        s1r;
        logic [2:0]  s1t;
        logic        s2r;
        logic [2:0]  s2t;
        logic [31:0] imm;
    } exp_t;

    logic tomasulo, reset, psel, penable, pwrite, pready, pslverr;
    logic [31:0] paddr, pwdata, prdata;
    logic cdb_valid, retire, rs_release;
    logic [2:0] cdb_tag;
    issue_pkg::rs_class_e rs_release_class;
    logic [1:0] rs_release_index;
    logic issue_valid, issue_src1_ready, issue_src2_ready;
    issue_pkg::op_e issue_op;
    issue_pkg::rs_class_e issue_class;
    logic [1:0] issue_rs_index;
    logic [2:0] issue_dest_tag, issue_src1_tag, issue_src2_tag;
    logic [31:0] issue_imm, issue_count;

    // model of the rename state, kept in dispatch order
    logic [2:0]  m_tag [32];
    logic [31:0] m_ready;
    logic [2:0]  m_busy [3];
    logic [2:0]  m_tail, m_head;
    int          m_count;

    exp_t        expq[$];
    exp_t        last_exp;
    logic [31:0] lfsr_state;
    logic [2:0]  dut_dest;
    int issued, errors, checks, cycles, tests, failed, err_mark;

    tb_clock #(.PERIOD(100)) u_clk (.clk(tomasulo));

    issue_top u_dut (.*);

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            r = {r[30:0], lfsr_state[0]};
        end
        return r;
    endfunction

    // expected issue record from the ISA fields and the rename state
    function automatic exp_t reference(input logic [31:0] w, input logic [2:0] tail,
                                       input logic [2:0] busy [3], input logic [2:0] tags [32],
                                       input logic [31:0] rdy);
        exp_t e;
        logic [2:0] f3;
        logic [4:0] rs1, rs2;
        f3 = w[14:12];
        e = '0;
        e.valid = 1'b1;
        rs1 = w[19:15];
        rs2 = 5'd0;
        e.imm = {{20{w[31]}}, w[31:20]};
        case (w[6:0])
            `OPC_RTYPE: begin
                e.cls = 2'd0;
                rs2 = w[24:20];
                e.imm = '0;
                case (f3)
                    3'd0: e.op = w[30] ? 6'd28 : 6'd27;
                    3'd5: e.op = w[30] ? 6'd34 : 6'd33;
                    default: e.op = 6'd28 + {3'd0, f3} + ((f3 > 3'd5) ? 6'd1 : 6'd0);
                endcase
            end
            `OPC_ITYPE: begin
                e.cls = 2'd1;
                case (f3)
                    3'd0: e.op = 6'd18;
                    3'd1: e.op = 6'd24;
                    3'd5: e.op = w[30] ? 6'd26 : 6'd25;
                    default: e.op = 6'd17 + {3'd0, f3} - ((f3 > 3'd5) ? 6'd1 : 6'd0);
                endcase
            end
            `OPC_LOAD: begin
                e.cls = 2'd2;
                case (f3)
                    3'd0, 3'd1, 3'd2: e.op = 6'd10 + {3'd0, f3};
                    3'd4, 3'd5: e.op = 6'd9 + {3'd0, f3};
                    default: e.valid = 1'b0;
                endcase
            end
            default: e.valid = 1'b0;
        endcase
        for (int i = 2; i >= 0; i--) begin
            if (!busy[e.cls][i]) e.slot = 2'(i);   // lowest free wins
        end
        e.dest = tail;
        e.s1r  = (rs1 == 5'd0) || rdy[rs1];
        e.s2r  = (rs2 == 5'd0) || rdy[rs2];
        e.s1t  = e.s1r ? 3'd0 : tags[rs1];
        e.s2t  = e.s2r ? 3'd0 : tags[rs2];
        return e;
    endfunction

    task automatic check_value(input string what, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR at %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic finish_test(input string name);
        tests++;
        if (errors != err_mark) failed++;
        $display("%s: %s", name, (errors == err_mark) ? "passed" : "failed");
        err_mark = errors;
    endtask

    function automatic void model_cdb(input logic [2:0] tag);
        for (int r = 0; r < 32; r++) begin
            if (!m_ready[r] && m_tag[r] == tag) m_ready[r] = 1'b1;
        end
    endfunction

    function automatic void model_retire();
        model_cdb(m_head);   // retired value lands in the register file
        m_head++;
        m_count--;
    endfunction

    task automatic apb_xfer(input logic wr, input logic [31:0] addr, input logic [31:0] wdata,
                            output logic [31:0] rdata, output logic err);
        @(posedge tomasulo);
        psel <= 1'b1;
        penable <= 1'b0;
        pwrite <= wr;
        paddr <= addr;
        pwdata <= wdata;
        @(posedge tomasulo);
        penable <= 1'b1;
        do @(posedge tomasulo); while (!pready);
        rdata = prdata;
        err = pslverr;
        psel <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic send_instr(input logic [31:0] w);
        exp_t e;
        logic [31:0] rd_unused;
        logic err;
        e = reference(w, m_tail, m_busy, m_tag, m_ready);
        if (e.valid) begin
            expq.push_back(e);
            last_exp = e;
            m_busy[e.cls][e.slot] = 1'b1;
            if (w[11:7] != 5'd0) begin
                m_tag[w[11:7]] = m_tail;
                m_ready[w[11:7]] = 1'b0;
            end
            m_tail++;
            m_count++;
        end
        apb_xfer(1'b1, `APB_INSTR_ADDR, w, rd_unused, err);
        check_value("pslverr on instruction write", 32'(err), 32'd0);
    endtask

    task automatic pulse_events(input logic cv, input logic [2:0] ct, input logic rt,
                                input logic rl, input logic [1:0] rc, input logic [1:0] ri);
        @(posedge tomasulo);
        cdb_valid <= cv;
        cdb_tag <= ct;
        retire <= rt;
        rs_release <= rl;
        rs_release_class <= issue_pkg::rs_class_e'(rc);
        rs_release_index <= ri;
        @(posedge tomasulo);
        cdb_valid <= 1'b0;
        retire <= 1'b0;
        rs_release <= 1'b0;
    endtask

    task automatic wait_issues(input int n);
        while (issued < n) @(posedge tomasulo);
    endtask

    // retire everything and free every slot so the next test starts clean
    task automatic flush_all();
        while (m_count > 0) begin
            pulse_events(1'b0, 3'd0, 1'b1, 1'b0, 2'd0, 2'd0);
            model_retire();
        end
        for (int c = 0; c < 3; c++) begin
            for (int s = 0; s < 3; s++) begin
                if (m_busy[c][s]) begin
                    pulse_events(1'b0, 3'd0, 1'b0, 1'b1, 2'(c), 2'(s));
                    m_busy[c][s] = 1'b0;
                end
            end
        end
    endtask

    function automatic logic [31:0] r_word(input logic [4:0] rd, input logic [4:0] rs1,
                                           input logic [4:0] rs2);
        return {7'd0, rs2, rs1, 3'd0, rd, `OPC_RTYPE};
    endfunction

    function automatic logic [31:0] i_word(input logic [4:0] rd, input logic [11:0] imm);
        return {imm, 5'd0, 3'd0, rd, `OPC_ITYPE};
    endfunction

    // compare every issue pulse with the oldest expected record
    always @(posedge tomasulo) begin : monitor
        exp_t e;
        if (reset && issue_valid) begin
            issued++;
            dut_dest = issue_dest_tag;
            if (expq.size() == 0) begin
                errors++;
                $display("an issue pulse came at time %0t with no instruction pending", $time);
            end else begin
                e = expq.pop_front();
                check_value("issue_op", 32'(issue_op), 32'(e.op));
                check_value("issue_class", 32'(issue_class), 32'(e.cls));
                check_value("issue_rs_index", 32'(issue_rs_index), 32'(e.slot));
                check_value("issue_dest_tag", 32'(issue_dest_tag), 32'(e.dest));
                check_value("issue_src1_ready", 32'(issue_src1_ready), 32'(e.s1r));
                check_value("issue_src1_tag", 32'(issue_src1_tag), 32'(e.s1t));
                check_value("issue_src2_ready", 32'(issue_src2_ready), 32'(e.s2r));
                check_value("issue_src2_tag", 32'(issue_src2_tag), 32'(e.s2t));
                check_value("issue_imm", issue_imm, e.imm);
            end
        end
    end

    always @(posedge tomasulo) begin : watchdog
        cycles++;
        if (cycles >= LIMIT) begin
            $display("timeout, the run did not finish within %0d cycles", LIMIT);
            $display("Errors found");
            $finish;
        end
    end

    initial begin
        logic [31:0] r, w, data;
        logic err;
        int base, kind;
        logic [2:0] first_dest;
        logic [2:0] prod_tag;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
        paddr = '0;
        pwdata = '0;
        cdb_valid = 1'b0;
        cdb_tag = '0;
        retire = 1'b0;
        rs_release = 1'b0;
        rs_release_class = issue_pkg::RS_ALU_R;
        rs_release_index = '0;
        reset = 1'b0;
        lfsr_state = 32'ha47b;
        for (int i = 0; i < 32; i++) m_tag[i] = '0;
        m_ready = '1;
        for (int c = 0; c < 3; c++) m_busy[c] = '0;
        m_tail = '0;
        m_head = '0;
        m_count = 0;
        repeat (8) @(posedge tomasulo);
        reset <= 1'b1;

        repeat (4) @(posedge tomasulo);
        check_value("issue pulses after reset", 32'(issued), 32'd0);
        apb_xfer(1'b0, `APB_COUNT_ADDR, '0, data, err);
        check_value("count after reset", data, 32'd0);
        check_value("pslverr on count read", 32'(err), 32'd0);
        apb_xfer(1'b0, 32'h8, '0, data, err);
        check_value("pslverr on address 8", 32'(err), 32'd1);
        finish_test("reset state");

        for (int n = 0; n < 60; n++) begin
            kind = int'(rand_bits(2)) % 3;
            r = rand_bits(31);
            if (kind == 0) begin
                w = {1'b0, r[3] & (r[2:0] == 3'd0 || r[2:0] == 3'd5), 5'd0, r[18:14],
                     r[13:9], r[2:0], r[8:4], `OPC_RTYPE};
            end else if (kind == 1) begin
                if (r[1:0] == 2'd1) r[30:19] = {1'b0, r[3] & r[2], 5'd0, r[23:19]};
                w = {r[30:19], r[13:9], r[2:0], r[8:4], `OPC_ITYPE};
            end else begin
                if (r[2:0] == 3'd3 || r[2:1] == 2'b11) r[2:0] = 3'd2;
                w = {r[30:19], r[13:9], r[2:0], r[8:4], `OPC_LOAD};
            end
            base = issued;
            send_instr(w);
            wait_issues(base + 1);
            pulse_events(1'b1, last_exp.dest, 1'b1, 1'b1, last_exp.cls, last_exp.slot);
            model_cdb(last_exp.dest);
            model_retire();
            m_busy[last_exp.cls][last_exp.slot] = 1'b0;
        end
        base = issued;
        for (int n = 0; n < 3; n++) begin
            r = rand_bits(20);
            send_instr({r[19:13], r[12:8], 5'd3, r[2:0], r[7:3], 7'b0100011});   // store
        end
        repeat (12) @(posedge tomasulo);
        check_value("issue pulses for stores", 32'(issued), 32'(base));
        finish_test("decoding");

        base = issued;
        send_instr(r_word(5'd5, 5'd0, 5'd0));
        prod_tag = m_tag[5];
        wait_issues(base + 1);
        send_instr(r_word(5'd6, 5'd5, 5'd0));    // reads the pending producer
        wait_issues(base + 2);
        pulse_events(1'b1, prod_tag, 1'b0, 1'b0, 2'd0, 2'd0);
        model_cdb(prod_tag);
        send_instr(r_word(5'd7, 5'd5, 5'd6));
        wait_issues(base + 3);
        send_instr(i_word(5'd0, 12'h7ff));       // writes r0, no rename
        wait_issues(base + 4);
        send_instr(i_word(5'd8, 12'h001));
        wait_issues(base + 5);
        flush_all();
        finish_test("renaming");

        base = issued;
        first_dest = m_tail;
        for (int k = 0; k < 8; k++) begin
            send_instr(i_word(5'(k + 1), 12'(k)));
            wait_issues(base + k + 1);
            pulse_events(1'b0, 3'd0, 1'b0, 1'b1, last_exp.cls, last_exp.slot);
            m_busy[last_exp.cls][last_exp.slot] = 1'b0;
        end
        model_retire();
        send_instr(i_word(5'd9, 12'hfff));
        repeat (15) @(posedge tomasulo);
        check_value("issue pulses while ROB full", 32'(issued), 32'(base + 8));
        pulse_events(1'b0, 3'd0, 1'b1, 1'b0, 2'd0, 2'd0);
        wait_issues(base + 9);
        check_value("wrapped dest tag", 32'(dut_dest), 32'(first_dest));
        flush_all();
        finish_test("ROB stall");

        base = issued;
        for (int k = 0; k < 3; k++) begin
            send_instr(r_word(5'(10 + k), 5'd0, 5'd0));
            wait_issues(base + k + 1);
        end
        m_busy[0][1] = 1'b0;
        send_instr(r_word(5'd13, 5'd0, 5'd0));
        send_instr(i_word(5'd14, 12'h123));      // must stay behind the stalled one
        repeat (15) @(posedge tomasulo);
        check_value("issue pulses while stations full", 32'(issued), 32'(base + 3));
        pulse_events(1'b0, 3'd0, 1'b0, 1'b1, 2'd0, 2'd1);
        wait_issues(base + 5);
        flush_all();
        finish_test("station stall");

        apb_xfer(1'b0, `APB_COUNT_ADDR, '0, data, err);
        check_value("dispatched count", data, 32'(issued));
        check_value("issue_count port", issue_count, 32'(issued));
        if (expq.size() != 0) begin
            errors++;
            $display("%0d expected instructions were never issued", expq.size());
        end
        finish_test("count");

        $display("tests %0d, failed %0d, checks %0d, errors %0d", tests, failed, checks, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

/* dv/tb_clock.sv */
// free running clock for the testbench
module tb_clock #(
    parameter int PERIOD = 100
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
    end

    always #(PERIOD / 2) clk = ~clk;

endmodule

/* logic/apb_fetch.sv */
`include "issue_defs.svh"

module apb_fetch (
    input  logic              tomasulo,
    input  logic              reset,
    input  logic              psel,
    input  logic              penable,
    input  logic              pwrite,
    input  issue_pkg::word_t  paddr,
    input  issue_pkg::word_t  pwdata,
    output logic              pready,
    output logic              pslverr,
    output issue_pkg::word_t  prdata,
    output logic              instr_valid,
    output issue_pkg::word_t  instr,
    input  logic              instr_ready,
    input  issue_pkg::count_t issue_count
);

    issue_pkg::fetch_state_e state;

    logic access;    // second phase of a transfer
    logic instr_wr;
    logic count_rd;
    logic accept;    // instruction write completes on this edge

    always_ff @(posedge tomasulo) begin
        if (!reset) begin
            state <= issue_pkg::IDLE;
        end else begin
            case (state)
                issue_pkg::IDLE: begin
                    if (psel && !penable) begin
                        state <= issue_pkg::ACCESS;
                    end
                end
                default: begin
                    // back to idle once done, or if the host abandons the transfer
                    if (pready || !psel) begin
                        state <= issue_pkg::IDLE;
                    end
                end
            endcase
        end
    end

    assign access   = (state == issue_pkg::ACCESS) && psel && penable;
    assign instr_wr = pwrite && (paddr == `APB_INSTR_ADDR);
    assign count_rd = !pwrite && (paddr == `APB_COUNT_ADDR);

    // a write waits while the buffer still holds the previous word
    assign pready  = access && (!instr_wr || !instr_valid);
    assign pslverr = access && !instr_wr && !count_rd;   // wrong address or direction
    assign prdata  = (access && count_rd) ? issue_count : '0;

    assign accept = access && instr_wr && !instr_valid;

    // one word buffer toward decode
    always_ff @(posedge tomasulo) begin
        if (!reset) begin
            instr_valid <= 1'b0;
        end else if (accept) begin
            instr_valid <= 1'b1;
        end else if (instr_ready) begin
            instr_valid <= 1'b0;
        end
    end

    always_ff @(posedge tomasulo) begin
        if (accept) begin
            instr <= pwdata;
        end
    end

endmodule

/* logic/dec_if.sv */
// decoded instruction travelling from decode to dispatch
interface dec_if;

    logic                 valid;
    issue_pkg::op_e       op;
    issue_pkg::rs_class_e rs_class;
    issue_pkg::reg_idx_t  rd;
    issue_pkg::reg_idx_t  rs1;      // zero when the format has no rs1
    issue_pkg::reg_idx_t  rs2;      // zero for I type and loads
    issue_pkg::imm_t      imm;
    logic                 ready;    // dispatch can take it this cycle

    modport dec_src (
        output valid,
        output op,
        output rs_class,
        output rd,
        output rs1,
        output rs2,
        output imm,
        input  ready
    );

    modport dec_dst (
        input  valid,
        input  op,
        input  rs_class,
        input  rd,
        input  rs1,
        input  rs2,
        input  imm,
        output ready
    );

endinterface

/* logic/decode.sv */
`include "issue_defs.svh"

module decode (
    input  logic             tomasulo,
    input  logic             reset,
    input  logic             instr_valid,
    input  issue_pkg::word_t instr,
    output logic             instr_ready,
    dec_if.dec_src           dec
);

    logic [6:0]           opcode;
    logic [2:0]           funct3;
    logic                 alt;          // bit 30 picks sub and arithmetic shifts
    logic                 supported;
    logic                 take;
    issue_pkg::op_e       op_d;
    issue_pkg::rs_class_e class_d;

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign alt    = instr[30];

    // free when empty or when dispatch drains it on this edge
    assign instr_ready = !dec.valid || dec.ready;
    assign take        = instr_valid && instr_ready;

    always_comb begin
        supported = 1'b1;
        op_d      = issue_pkg::OP_ADD;
        class_d   = issue_pkg::RS_ALU_R;
        case (opcode)
            `OPC_RTYPE: begin
                class_d = issue_pkg::RS_ALU_R;
                case (funct3)
                    3'd0:    op_d = alt ? issue_pkg::OP_SUB : issue_pkg::OP_ADD;
                    3'd1:    op_d = issue_pkg::OP_SLL;
                    3'd2:    op_d = issue_pkg::OP_SLT;
                    3'd3:    op_d = issue_pkg::OP_SLTU;
                    3'd4:    op_d = issue_pkg::OP_XOR;
                    3'd5:    op_d = alt ? issue_pkg::OP_SRA : issue_pkg::OP_SRL;
                    3'd6:    op_d = issue_pkg::OP_OR;
                    default: op_d = issue_pkg::OP_AND;
                endcase
            end
            `OPC_ITYPE: begin
                class_d = issue_pkg::RS_ALU_I;
                case (funct3)
                    3'd0:    op_d = issue_pkg::OP_ADDI;
                    3'd1:    op_d = issue_pkg::OP_SLLI;
                    3'd2:    op_d = issue_pkg::OP_SLTI;
                    3'd3:    op_d = issue_pkg::OP_SLTIU;
                    3'd4:    op_d = issue_pkg::OP_XORI;
                    3'd5:    op_d = alt ? issue_pkg::OP_SRAI : issue_pkg::OP_SRLI;
                    3'd6:    op_d = issue_pkg::OP_ORI;
                    default: op_d = issue_pkg::OP_ANDI;
                endcase
            end
            `OPC_LOAD: begin
                class_d = issue_pkg::RS_LOAD;
                case (funct3)
                    3'd0:    op_d = issue_pkg::OP_LB;
                    3'd1:    op_d = issue_pkg::OP_LH;
                    3'd2:    op_d = issue_pkg::OP_LW;
                    3'd4:    op_d = issue_pkg::OP_LBU;
                    3'd5:    op_d = issue_pkg::OP_LHU;
                    default: supported = 1'b0;   // no such load width
                endcase
            end
            default: supported = 1'b0;           // stores and the rest are dropped
        endcase
    end

    always_ff @(posedge tomasulo) begin
        if (!reset) begin
            dec.valid <= 1'b0;
        end else if (take) begin
            dec.valid <= supported;
        end else if (dec.ready) begin
            dec.valid <= 1'b0;
        end
    end

    always_ff @(posedge tomasulo) begin
        if (take) begin
            dec.op       <= op_d;
            dec.rs_class <= class_d;
            dec.rd       <= instr[11:7];
            dec.rs1      <= instr[19:15];
            dec.rs2      <= (opcode == `OPC_RTYPE) ? instr[24:20] : '0;
            // R type carries no immediate
            dec.imm      <= (opcode == `OPC_RTYPE) ? '0
                                                   : {{(`XLEN-12){instr[31]}}, instr[31:20]};
        end
    end

endmodule

/* logic/dispatch.sv */
`include "issue_defs.svh"

module dispatch (
    input  logic                 tomasulo,
    input  logic                 reset,
    input  logic                 cdb_valid,
    input  issue_pkg::tag_t      cdb_tag,
    input  logic                 retire,
    input  logic                 rs_release,
    input  issue_pkg::rs_class_e rs_release_class,
    input  issue_pkg::rs_idx_t   rs_release_index,
    dec_if.dec_dst               dec,
    output logic                 issue_valid,
    output issue_pkg::op_e       issue_op,
    output issue_pkg::rs_class_e issue_class,
    output issue_pkg::rs_idx_t   issue_rs_index,
    output issue_pkg::tag_t      issue_dest_tag,
    output logic                 issue_src1_ready,
    output issue_pkg::tag_t      issue_src1_tag,
    output logic                 issue_src2_ready,
    output issue_pkg::tag_t      issue_src2_tag,
    output issue_pkg::imm_t      issue_imm,
    output issue_pkg::count_t    issue_count
);

    // register alias table
    issue_pkg::tag_t        rat_tag [`REG_COUNT];
    logic [`REG_COUNT-1:0]  rat_ready;

    issue_pkg::tag_t        rob_head;
    issue_pkg::tag_t        rob_tail;
    logic [`TAG_W:0]        rob_count;      // 0 to ROB_DEPTH
    logic                   rob_block;
    logic                   retire_ok;

    logic [`RS_DEPTH-1:0]   rs_busy [3];    // indexed by rs_class_e
    logic [`RS_DEPTH-1:0]   release_mask;
    logic [`RS_DEPTH-1:0]   slot_free;
    logic [`RS_DEPTH-1:0]   alloc_mask;
    logic                   slot_found;
    issue_pkg::rs_idx_t     slot_idx;

    logic                   src1_ready;
    logic                   src2_ready;
    issue_pkg::tag_t        src1_tag;
    issue_pkg::tag_t        src2_tag;
    logic                   fire;

    assign retire_ok    = retire && (rob_count != '0);
    assign rob_block    = (rob_count == `ROB_DEPTH) && !retire;   // same edge retire frees one
    assign release_mask = rs_release ? (`RS_DEPTH'(1) << rs_release_index) : '0;

    assign slot_free = ~rs_busy[dec.rs_class]
                     | ((rs_release_class == dec.rs_class) ? release_mask : '0);

    // lowest free slot wins
    always_comb begin
        slot_found = 1'b0;
        slot_idx   = '0;
        for (int i = `RS_DEPTH - 1; i >= 0; i--) begin
            if (slot_free[i]) begin
                slot_found = 1'b1;
                slot_idx   = issue_pkg::rs_idx_t'(i);
            end
        end
    end

    assign alloc_mask = `RS_DEPTH'(1) << slot_idx;
    assign dec.ready  = !rob_block && slot_found;
    assign fire       = dec.valid && dec.ready;

    // reads see the table before this edge, a same cycle broadcast still shows pending
    assign src1_ready = (dec.rs1 == '0) || rat_ready[dec.rs1];
    assign src2_ready = (dec.rs2 == '0) || rat_ready[dec.rs2];
    assign src1_tag   = src1_ready ? '0 : rat_tag[dec.rs1];
    assign src2_tag   = src2_ready ? '0 : rat_tag[dec.rs2];

    always_ff @(posedge tomasulo) begin
        if (!reset) begin
            for (int r = 0; r < `REG_COUNT; r++) begin
                rat_tag[r]   <= '0;
                rat_ready[r] <= 1'b1;
            end
        end else begin
            for (int r = 0; r < `REG_COUNT; r++) begin
                if (!rat_ready[r] && cdb_valid && rat_tag[r] == cdb_tag) begin
                    rat_ready[r] <= 1'b1;
                end
                // retired value sits in the register file now, so the tag can be reused
                if (!rat_ready[r] && retire_ok && rat_tag[r] == rob_head) begin
                    rat_ready[r] <= 1'b1;
                end
            end
            if (fire && dec.rd != '0) begin   // rename wins over a clear of the same register
                rat_tag[dec.rd]   <= rob_tail;
                rat_ready[dec.rd] <= 1'b0;
            end
        end
    end

    always_ff @(posedge tomasulo) begin
        if (!reset) begin
            rob_head  <= '0;
            rob_tail  <= '0;
            rob_count <= '0;
        end else begin
            if (fire) begin
                rob_tail <= (rob_tail == `TAG_W'(`ROB_DEPTH - 1)) ? '0 : rob_tail + 1'b1;
            end
            if (retire_ok) begin
                rob_head <= (rob_head == `TAG_W'(`ROB_DEPTH - 1)) ? '0 : rob_head + 1'b1;
            end
            case ({fire, retire_ok})
                2'b10:   rob_count <= rob_count + 1'b1;
                2'b01:   rob_count <= rob_count - 1'b1;
                default: rob_count <= rob_count;
            endcase
        end
    end

    // busy masks, release first then allocate
    always_ff @(posedge tomasulo) begin
        if (!reset) begin
            for (int c = 0; c < 3; c++) begin
                rs_busy[c] <= '0;
            end
        end else begin
            for (int c = 0; c < 3; c++) begin
                rs_busy[c] <= (rs_busy[c]
                    & ~((rs_release_class == issue_pkg::rs_class_e'(c)) ? release_mask : '0))
                    | ((fire && dec.rs_class == issue_pkg::rs_class_e'(c)) ? alloc_mask : '0);
            end
        end
    end

    always_ff @(posedge tomasulo) begin
        if (!reset) begin
            issue_valid <= 1'b0;
            issue_count <= '0;
        end else begin
            issue_valid <= fire;      // one pulse per dispatch
            if (fire) begin
                issue_count <= issue_count + 1'b1;
            end
        end
    end

    always_ff @(posedge tomasulo) begin
        if (fire) begin
            issue_op         <= dec.op;
            issue_class      <= dec.rs_class;
            issue_rs_index   <= slot_idx;
            issue_dest_tag   <= rob_tail;
            issue_src1_ready <= src1_ready;
            issue_src1_tag   <= src1_tag;
            issue_src2_ready <= src2_ready;
            issue_src2_tag   <= src2_tag;
            issue_imm        <= dec.imm;
        end
    end

endmodule

/* logic/issue_defs.svh */
`ifndef ISSUE_DEFS_SVH
`define ISSUE_DEFS_SVH

// reorder buffer, one tag per entry
`define ROB_DEPTH 8
`define TAG_W 3

// reservation stations, slots per class
`define RS_DEPTH 3
`define RS_IDX_W 2

// architectural registers
`define REG_COUNT 32
`define REG_W 5

`define XLEN 32

// major opcodes accepted by decode
`define OPC_RTYPE 7'b0110011
`define OPC_ITYPE 7'b0010011
`define OPC_LOAD 7'b0000011

// host register map
`define APB_INSTR_ADDR 32'h0000_0000 // write only, instruction word
`define APB_COUNT_ADDR 32'h0000_0004 // read only, dispatched count

`endif

/* logic/issue_pkg.sv */
`include "issue_defs.svh"

package issue_pkg;

    typedef logic [`XLEN-1:0] word_t;
    typedef logic [`REG_W-1:0] reg_idx_t;
    typedef logic [`TAG_W-1:0] tag_t;     // reorder buffer entry
    typedef logic [`RS_IDX_W-1:0] rs_idx_t;
    typedef logic [`XLEN-1:0] imm_t;      // already sign extended
    typedef logic [`XLEN-1:0] count_t;

    typedef enum logic [1:0] {
        RS_ALU_R = 2'd0,
        RS_ALU_I = 2'd1,
        RS_LOAD  = 2'd2
    } rs_class_e;

    // internal operation codes, same numbering as the older issue stage
    typedef enum logic [5:0] {
        OP_LB    = 6'd10,
        OP_LH    = 6'd11,
        OP_LW    = 6'd12,
        OP_LBU   = 6'd13,
        OP_LHU   = 6'd14,
        OP_ADDI  = 6'd18,
        OP_SLTI  = 6'd19,
        OP_SLTIU = 6'd20,
        OP_XORI  = 6'd21,
        OP_ORI   = 6'd22,
        OP_ANDI  = 6'd23,
        OP_SLLI  = 6'd24,
        OP_SRLI  = 6'd25,
        OP_SRAI  = 6'd26,
        OP_ADD   = 6'd27,
        OP_SUB   = 6'd28,
        OP_SLL   = 6'd29,
        OP_SLT   = 6'd30,
        OP_SLTU  = 6'd31,
        OP_XOR   = 6'd32,
        OP_SRL   = 6'd33,
        OP_SRA   = 6'd34,
        OP_OR    = 6'd35,
        OP_AND   = 6'd36
    } op_e;

    typedef enum logic {
        IDLE,   // no transfer or setup phase pending
        ACCESS  // setup seen, waiting for penable
    } fetch_state_e;

endpackage

/* logic/issue_top.sv */
module issue_top (
    input  logic                 tomasulo,
    input  logic                 reset,
    input  logic                 psel,
    input  logic                 penable,
    input  logic                 pwrite,
    input  issue_pkg::word_t     paddr,
    input  issue_pkg::word_t     pwdata,
    output logic                 pready,
    output logic                 pslverr,
    output issue_pkg::word_t     prdata,
    input  logic                 cdb_valid,
    input  issue_pkg::tag_t      cdb_tag,
    input  logic                 retire,
    input  logic                 rs_release,
    input  issue_pkg::rs_class_e rs_release_class,
    input  issue_pkg::rs_idx_t   rs_release_index,
    output logic                 issue_valid,
    output issue_pkg::op_e       issue_op,
    output issue_pkg::rs_class_e issue_class,
    output issue_pkg::rs_idx_t   issue_rs_index,
    output issue_pkg::tag_t      issue_dest_tag,
    output logic                 issue_src1_ready,
    output issue_pkg::tag_t      issue_src1_tag,
    output logic                 issue_src2_ready,
    output issue_pkg::tag_t      issue_src2_tag,
    output issue_pkg::imm_t      issue_imm,
    output issue_pkg::count_t    issue_count
);

    logic             instr_valid;
    logic             instr_ready;
    issue_pkg::word_t instr;

    dec_if dec_bus ();   // decode to dispatch

    apb_fetch u_fetch (
        .tomasulo(tomasulo), .reset(reset),
        .psel(psel), .penable(penable), .pwrite(pwrite),
        .paddr(paddr), .pwdata(pwdata),
        .pready(pready), .pslverr(pslverr), .prdata(prdata),
        .instr_valid(instr_valid), .instr(instr), .instr_ready(instr_ready),
        .issue_count(issue_count)   // count read comes back from dispatch
    );

    decode u_decode (
        .tomasulo(tomasulo), .reset(reset),
        .instr_valid(instr_valid), .instr(instr), .instr_ready(instr_ready),
        .dec(dec_bus.dec_src)
    );

    dispatch u_dispatch (
        .tomasulo(tomasulo), .reset(reset),
        .cdb_valid(cdb_valid), .cdb_tag(cdb_tag), .retire(retire),
        .rs_release(rs_release), .rs_release_class(rs_release_class),
        .rs_release_index(rs_release_index),
        .dec(dec_bus.dec_dst),
        .issue_valid(issue_valid), .issue_op(issue_op), .issue_class(issue_class),
        .issue_rs_index(issue_rs_index), .issue_dest_tag(issue_dest_tag),
        .issue_src1_ready(issue_src1_ready), .issue_src1_tag(issue_src1_tag),
        .issue_src2_ready(issue_src2_ready), .issue_src2_tag(issue_src2_tag),
        .issue_imm(issue_imm), .issue_count(issue_count)
    );

endmodule

/* run.sh */
#!/bin/sh
# build and run the issue stage testbench, result taken from sim.log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary -f all.f --top-module issue_tb -o issue_sim \
    && ./obj_dir/issue_sim | tee sim.log \
    || { echo "build or run failed"; exit 1; }
grep -q "No errors" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
